// ==== snake_pkg.sv ====
package snake_pkg;

    // ========================================================================
    // grid and timing
    // ========================================================================

    localparam int COORD_BITS  = 4;
    localparam int MAX_LENGTH  = 50;
    localparam int TICK_CYCLES = 8;

    // head at x 4, y 5
    localparam logic [7:0] START_CELL   = 8'h45;
    localparam logic [7:0] START_LENGTH = 8'd2;

    // ========================================================================
    // apple placement lfsr
    // ========================================================================

    localparam logic [7:0] APPLE_SEED = 8'h5A;
    localparam logic [7:0] APPLE_TAPS = 8'hB8;

    typedef enum logic [1:0] {
        UP,
        DOWN,
        LEFT,
        RIGHT
    } direction_t;

    typedef struct packed {
        logic [COORD_BITS-1:0] x;
        logic [COORD_BITS-1:0] y;
    } cell_pos_t;

    // raw for compares, pos for movement
    typedef union packed {
        logic [7:0] raw;
        cell_pos_t  pos;
    } cell_t;

endpackage

// ==== move_tick.sv ====
`timescale 1ns/1ps

module move_tick import snake_pkg::*; (
    input  logic clk,
    input  logic nrst,
    input  logic sync,
    input  logic game_over,
    output logic step
);

    logic [$clog2(TICK_CYCLES)-1:0] count;
    logic                           wrap;

    assign wrap = (count == $bits(count)'(TICK_CYCLES - 1));

    // step is registered so it comes TICK_CYCLES edges after reset
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            count <= '0;
            step  <= 1'b0;
        end else if (sync) begin
            count <= '0;
            step  <= 1'b0;
        end else if (game_over) begin
            // frozen until sync
            step <= 1'b0;
        end else begin
            step <= wrap;
            if (wrap) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

// ==== heading_ctrl.sv ====
`timescale 1ns/1ps

module heading_ctrl import snake_pkg::*; (
    input  logic       clk,
    input  logic       nrst,
    input  logic       sync,
    input  logic       btn_up,
    input  logic       btn_down,
    input  logic       btn_left,
    input  logic       btn_right,
    output direction_t direction
);

    direction_t req_dir;
    logic       req_valid;
    logic       accept;

    function automatic direction_t reverse_of(input direction_t dir);
        direction_t rev;
        case (dir)
            UP:      rev = DOWN;
            DOWN:    rev = UP;
            LEFT:    rev = RIGHT;
            default: rev = LEFT;
        endcase
        return rev;
    endfunction

    // priority up, down, left, right
    always_comb begin
        req_valid = 1'b1;
        req_dir   = direction;
        if (btn_up) begin
            req_dir = UP;
        end else if (btn_down) begin
            req_dir = DOWN;
        end else if (btn_left) begin
            req_dir = LEFT;
        end else if (btn_right) begin
            req_dir = RIGHT;
        end else begin
            req_valid = 1'b0;
        end
    end

    // snake cannot fold back onto its own neck
    assign accept = req_valid && (req_dir != reverse_of(direction));

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            direction <= RIGHT;
        end else if (sync) begin
            direction <= RIGHT;
        end else if (accept) begin
            direction <= req_dir;
        end
    end

endmodule

// ==== update_body.sv ====
`timescale 1ns/1ps

module update_body import snake_pkg::*; (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    sync,
    input  logic                    step,
    input  direction_t              direction,
    input  logic [7:0]              length,
    output cell_t [MAX_LENGTH-1:0]  body,
    output cell_t                   head
);

    cell_t [MAX_LENGTH-1:0] current;
    cell_t [MAX_LENGTH-1:0] next;
    cell_t                  next_head;

    // ========================================================================
    // segment registers
    // ========================================================================

    generate
        for (genvar i = 0; i < MAX_LENGTH; i++) begin : g_cell
            always_ff @(posedge clk or negedge nrst) begin
                if (!nrst) begin
                    if (i == 0) begin
                        current[i].raw <= START_CELL;
                    end else begin
                        current[i].raw <= 8'h00;
                    end
                end else begin
                    current[i] <= next[i];
                end
            end
        end
    endgenerate

    // ========================================================================
    // next head with coordinates wrapping modulo 16
    // ========================================================================

    always_comb begin
        next_head = current[0];
        case (direction)
            LEFT:    next_head.pos.x = current[0].pos.x - 1'b1;
            RIGHT:   next_head.pos.x = current[0].pos.x + 1'b1;
            DOWN:    next_head.pos.y = current[0].pos.y + 1'b1;
            UP:      next_head.pos.y = current[0].pos.y - 1'b1;
            default: next_head = current[0];
        endcase
    end

    // shift limited by the length before this step
    always_comb begin
        if (sync) begin
            for (int i = 0; i < MAX_LENGTH; i++) begin
                if (i == 0) begin
                    next[i].raw = START_CELL;
                end else begin
                    next[i].raw = 8'h00;
                end
            end
        end else if (step) begin
            for (int i = 0; i < MAX_LENGTH; i++) begin
                if (i == 0) begin
                    next[i] = next_head;
                end else if (i <= length) begin
                    next[i] = current[i-1];
                end else begin
                    next[i].raw = 8'h00;
                end
            end
        end else begin
            next = current;
        end
    end

    assign body = current;
    assign head = next_head;

endmodule

// ==== collision_check.sv ====
`timescale 1ns/1ps

module collision_check import snake_pkg::*; (
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   sync,
    input  logic                   step,
    input  cell_t [MAX_LENGTH-1:0] body,
    input  logic [7:0]             length,
    output logic                   game_over
);

    logic step_d;
    logic hit;

    // body registers settle on the step edge so the check looks one cycle later
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            step_d <= 1'b0;
        end else if (sync) begin
            step_d <= 1'b0;
        end else begin
            step_d <= step;
        end
    end

    // ========================================================================
    // head against live segments 1..length
    // ========================================================================

    always_comb begin
        hit = 1'b0;
        for (int i = 1; i < MAX_LENGTH; i++) begin
            if ((i <= length) && (body[i].raw == body[0].raw)) begin
                hit = 1'b1;
            end
        end
    end

    // sticky until sync or reset
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            game_over <= 1'b0;
        end else if (sync) begin
            game_over <= 1'b0;
        end else if (step_d && hit) begin
            game_over <= 1'b1;
        end
    end

endmodule

// ==== food_growth.sv ====
`timescale 1ns/1ps

module food_growth import snake_pkg::*; (
    input  logic       clk,
    input  logic       nrst,
    input  logic       sync,
    input  logic       step,
    input  cell_t      head,
    output logic [7:0] length,
    output cell_t      apple
);

    logic  eat;
    logic  at_max;
    cell_t shift_once;
    cell_t shift_twice;
    cell_t apple_next;

    // galois form that shifts right and folds the taps in when a one drops out
    function automatic logic [7:0] lfsr_step(input logic [7:0] value);
        logic [7:0] shifted;
        shifted = value >> 1;
        if (value[0]) begin
            shifted = shifted ^ APPLE_TAPS;
        end
        return shifted;
    endfunction

    assign eat    = step && (head.raw == apple.raw);
    assign at_max = (length >= 8'(MAX_LENGTH - 1));

    // ========================================================================
    // apple relocation
    // ========================================================================

    always_comb begin
        shift_once.raw  = lfsr_step(apple.raw);
        shift_twice.raw = lfsr_step(shift_once.raw);
        // never drop the new apple under the head
        if (shift_once.raw == head.raw) begin
            apple_next = shift_twice;
        end else begin
            apple_next = shift_once;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            apple.raw <= APPLE_SEED;
        end else if (sync) begin
            apple.raw <= APPLE_SEED;
        end else if (eat) begin
            apple <= apple_next;
        end
    end

    // ========================================================================
    // length counter
    // ========================================================================

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            length <= START_LENGTH;
        end else if (sync) begin
            length <= START_LENGTH;
        end else if (eat && !at_max) begin
            length <= length + 8'd1;
        end
    end

endmodule

// ==== snake_core.sv ====
`timescale 1ns/1ps

module snake_core import snake_pkg::*; (
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   sync,
    input  logic                   btn_up,
    input  logic                   btn_down,
    input  logic                   btn_left,
    input  logic                   btn_right,
    output cell_t [MAX_LENGTH-1:0] body,
    output cell_t                  head,
    output cell_t                  apple,
    output logic [7:0]             length,
    output logic                   game_over,
    output logic                   step
);

    direction_t direction;

    move_tick move_tick_inst (
        .clk       (clk),
        .nrst      (nrst),
        .sync      (sync),
        .game_over (game_over),
        .step      (step)
    );

    heading_ctrl heading_ctrl_inst (
        .clk       (clk),
        .nrst      (nrst),
        .sync      (sync),
        .btn_up    (btn_up),
        .btn_down  (btn_down),
        .btn_left  (btn_left),
        .btn_right (btn_right),
        .direction (direction)
    );

    update_body update_body_inst (
        .clk       (clk),
        .nrst      (nrst),
        .sync      (sync),
        .step      (step),
        .direction (direction),
        .length    (length),
        .body      (body),
        .head      (head)
    );

    // sees the shifted body one cycle after step
    collision_check collision_check_inst (
        .clk       (clk),
        .nrst      (nrst),
        .sync      (sync),
        .step      (step),
        .body      (body),
        .length    (length),
        .game_over (game_over)
    );

    food_growth food_growth_inst (
        .clk       (clk),
        .nrst      (nrst),
        .sync      (sync),
        .step      (step),
        .head      (head),
        .length    (length),
        .apple     (apple)
    );

endmodule

// ==== tb_snake_core.sv ====
`timescale 1ns/1ps

module tb_snake_core import snake_pkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int STIM_DEPTH   = 64;

    logic                   clk;
    logic                   nrst;
    logic                   sync;
    logic                   btn_up;
    logic                   btn_down;
    logic                   btn_left;
    logic                   btn_right;
    cell_t [MAX_LENGTH-1:0] body;
    cell_t                  head;
    cell_t                  apple;
    logic [7:0]             length;
    logic                   game_over;
    logic                   step;

    // one word per step with btn, sync, head, length, apple and game_over
    logic [35:0] stim_mem [0:STIM_DEPTH-1];
    int          stim_lines;
    logic        stim_ready;

    int value_errors;
    int stim_errors;
    int other_errors;

    // reference model of the game rules
    cell_t [MAX_LENGTH-1:0] model_body;
    logic [7:0]             model_len;
    cell_t                  model_apple;
    direction_t             model_dir;
    logic                   model_over;

    snake_core snake_core_inst (
        .clk       (clk),
        .nrst      (nrst),
        .sync      (sync),
        .btn_up    (btn_up),
        .btn_down  (btn_down),
        .btn_left  (btn_left),
        .btn_right (btn_right),
        .body      (body),
        .head      (head),
        .apple     (apple),
        .length    (length),
        .game_over (game_over),
        .step      (step)
    );

    always #2 clk = ~clk;

    // ========================================================================
    // compare tasks
    // ========================================================================

    task automatic check_cell(input string name, input cell_t expected, input cell_t actual);
        if (actual.raw !== expected.raw) begin
            value_errors++;
            $display("ERR %s expected %02h actual %02h", name, expected.raw, actual.raw);
        end
    endtask

    task automatic check_length(input string name, input logic [7:0] expected,
                                input logic [7:0] actual);
        if (actual !== expected) begin
            value_errors++;
            $display("ERR %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            value_errors++;
            $display("ERR %s expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic compare_stim(input int line, input string what,
                                input logic [7:0] in_file, input logic [7:0] from_rules);
        if (in_file !== from_rules) begin
            stim_errors++;
            $display("stimulus error on step %0d: %s is %02h in the file but the rules give %02h",
                     line, what, in_file, from_rules);
        end
    endtask

    task automatic report_counts();
        $display("errors: %0d wrong values, %0d stimulus errors, %0d other failures",
                 value_errors, stim_errors, other_errors);
    endtask

    // ========================================================================
    // rule model
    // ========================================================================

    task automatic model_reset();
        for (int i = 0; i < MAX_LENGTH; i++) begin
            model_body[i].raw = 8'h00;
        end
        model_body[0].raw = START_CELL;
        model_len         = START_LENGTH;
        model_apple.raw   = APPLE_SEED;
        model_dir         = RIGHT;
        model_over        = 1'b0;
    endtask

    function automatic direction_t button_dir(input logic [3:0] code);
        case (code)
            4'd1:    return UP;
            4'd2:    return DOWN;
            4'd3:    return LEFT;
            default: return RIGHT;
        endcase
    endfunction

    function automatic logic is_reversal(input direction_t now, input direction_t req);
        return (now == UP && req == DOWN) || (now == DOWN && req == UP) ||
               (now == LEFT && req == RIGHT) || (now == RIGHT && req == LEFT);
    endfunction

    // one cell over in the given direction with wrap on the 16 by 16 grid
    function automatic cell_t moved_cell(input cell_t from, input direction_t dir);
        int    x;
        int    y;
        cell_t res;
        x = from.pos.x;
        y = from.pos.y;
        case (dir)
            UP:      y = (y + 15) % 16;
            DOWN:    y = (y + 1) % 16;
            LEFT:    x = (x + 15) % 16;
            default: x = (x + 1) % 16;
        endcase
        res.pos.x = x[3:0];
        res.pos.y = y[3:0];
        return res;
    endfunction

    function automatic cell_t apple_shift(input cell_t from);
        cell_t res;
        res.raw = {1'b0, from.raw[7:1]};
        if (from.raw[0]) begin
            res.raw = res.raw ^ APPLE_TAPS;
        end
        return res;
    endfunction

    task automatic model_step(input logic [3:0] code, input logic do_sync);
        cell_t new_head;
        logic  eat;
        if (do_sync) begin
            model_reset();
        end else if (code != 4'd0 && !is_reversal(model_dir, button_dir(code))) begin
            model_dir = button_dir(code);
        end
        new_head = moved_cell(model_body[0], model_dir);
        eat      = (new_head.raw == model_apple.raw);
        // walk down so each cell still reads its old neighbour
        for (int i = MAX_LENGTH - 1; i > 0; i--) begin
            if (i <= model_len) begin
                model_body[i] = model_body[i-1];
            end else begin
                model_body[i].raw = 8'h00;
            end
        end
        model_body[0] = new_head;
        if (eat) begin
            if (model_len < MAX_LENGTH - 1) begin
                model_len = model_len + 8'd1;
            end
            model_apple = apple_shift(model_apple);
            if (model_apple.raw == new_head.raw) begin
                model_apple = apple_shift(model_apple);
            end
        end
        for (int i = 1; i < MAX_LENGTH; i++) begin
            if (i <= model_len && model_body[i].raw == model_body[0].raw) begin
                model_over = 1'b1;
            end
        end
    endtask

    // ========================================================================
    // stimulus
    // ========================================================================

    task automatic apply_inputs(input logic [3:0] code, input logic do_sync);
        @(posedge clk);
        #1;
        btn_up    = (code == 4'd1);
        btn_down  = (code == 4'd2);
        btn_left  = (code == 4'd3);
        btn_right = (code == 4'd4);
        sync      = do_sync;
        @(posedge clk);
        #1;
        btn_up    = 1'b0;
        btn_down  = 1'b0;
        btn_left  = 1'b0;
        btn_right = 1'b0;
        sync      = 1'b0;
    endtask

    task automatic run_line(input int n);
        logic [35:0] word;
        logic [3:0]  code;
        logic        do_sync;
        cell_t       exp_head;
        logic [7:0]  exp_len;
        cell_t       exp_apple;
        logic        exp_over;
        word         = stim_mem[n];
        code         = word[35:32];
        do_sync      = word[28];
        exp_head.raw = word[27:20];
        exp_len      = word[19:12];
        exp_apple.raw = word[11:4];
        exp_over     = word[0];

        model_step(code, do_sync);
        compare_stim(n, "head", exp_head.raw, model_body[0].raw);
        compare_stim(n, "length", exp_len, model_len);
        compare_stim(n, "apple", exp_apple.raw, model_apple.raw);
        compare_stim(n, "game_over", {7'd0, exp_over}, {7'd0, model_over});

        apply_inputs(code, do_sync);
        do begin
            @(negedge clk);
        end while (step !== 1'b1);
        check_cell($sformatf("step %0d head", n), exp_head, head);

        // update edge
        @(posedge clk);
        @(negedge clk);
        check_length($sformatf("step %0d length", n), exp_len, length);
        check_cell($sformatf("step %0d apple", n), exp_apple, apple);
        for (int i = 0; i < MAX_LENGTH; i++) begin
            check_cell($sformatf("step %0d cell %0d", n, i), model_body[i], body[i]);
        end

        // collision edge
        @(posedge clk);
        @(negedge clk);
        check_flag($sformatf("step %0d game_over", n), exp_over, game_over);
        if (exp_over) begin
            repeat (2 * TICK_CYCLES) begin
                @(negedge clk);
                check_flag($sformatf("step %0d step after game over", n), 1'b0, step);
                check_flag($sformatf("step %0d game_over held", n), 1'b1, game_over);
            end
        end
    endtask

    // ========================================================================
    // main sequence
    // ========================================================================

    initial begin
        clk          = 1'b0;
        nrst         = 1'b0;
        sync         = 1'b0;
        btn_up       = 1'b0;
        btn_down     = 1'b0;
        btn_left     = 1'b0;
        btn_right    = 1'b0;
        value_errors = 0;
        stim_errors  = 0;
        other_errors = 0;
        stim_ready   = 1'b0;

        for (int i = 0; i < STIM_DEPTH; i++) begin
            stim_mem[i] = '1;
        end
        $readmemh("snake_stim.txt", stim_mem);
        stim_lines = 0;
        while (stim_lines < STIM_DEPTH && stim_mem[stim_lines] !== '1) begin
            stim_lines++;
        end
        stim_ready = 1'b1;
        if (stim_lines == 0) begin
            other_errors++;
            $display("no stimulus lines could be read from snake_stim.txt");
        end

        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        nrst = 1'b1;

        // state straight out of reset
        @(negedge clk);
        for (int i = 0; i < MAX_LENGTH; i++) begin
            check_cell($sformatf("reset cell %0d", i), model_body[i], body[i]);
        end
        check_length("reset length", model_len, length);
        check_cell("reset apple", model_apple, apple);
        check_flag("reset game_over", 1'b0, game_over);
        check_flag("reset step", 1'b0, step);

        for (int n = 0; n < stim_lines; n++) begin
            run_line(n);
        end

        report_counts();
        if (value_errors == 0 && stim_errors == 0 && other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog sized from the number of steps in the file
    initial begin
        time limit;
        wait (stim_ready);
        limit = (stim_lines * TICK_CYCLES + RESET_CYCLES + 16 * TICK_CYCLES) * 4;
        #(limit);
        $display("timeout: the DUT stopped issuing steps before the stimulus was done");
        report_counts();
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== snake_stim.txt ====
// one step per line: button _ sync _ head _ length _ apple _ game_over, all hex
// button 0 none, 1 up, 2 down, 3 left, 4 right
// first step out of reset, then a reversal that must be ignored
0_0_55_02_5a_0
3_0_65_02_5a_0
// turn down and walk to the first apple
2_0_66_02_5a_0
0_0_67_02_5a_0
0_0_68_02_5a_0
0_0_69_02_5a_0
0_0_6a_02_5a_0
3_0_5a_03_2d_0
// head left then down onto the second apple
0_0_4a_03_2d_0
0_0_3a_03_2d_0
0_0_2a_03_2d_0
2_0_2b_03_2d_0
0_0_2c_03_2d_0
0_0_2d_04_ae_0
// loop back into the body
4_0_3d_04_ae_0
1_0_3c_04_ae_0
3_0_2c_04_ae_1
// restart, then run right across the edge
0_1_55_02_5a_0
0_0_65_02_5a_0
0_0_75_02_5a_0
0_0_85_02_5a_0
0_0_95_02_5a_0
0_0_a5_02_5a_0
0_0_b5_02_5a_0
0_0_c5_02_5a_0
0_0_d5_02_5a_0
0_0_e5_02_5a_0
0_0_f5_02_5a_0
0_0_05_02_5a_0
0_0_15_02_5a_0

// ==== snake_core.f ====
snake_pkg.sv
move_tick.sv
heading_ctrl.sv
update_body.sv
collision_check.sv
food_growth.sv
snake_core.sv
tb_snake_core.sv
